// ==== list.f ====
src/iommu_fq_pkg.sv
src/fq_regs.sv
src/fq_record_builder.sv
src/fq_handler.sv
src/fq_mem_writer.sv
src/iommu_fq_top.sv
sim/fq_asserts.sv
sim/tb_iommu_fq_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_iommu_fq_top
FILELIST  ?= list.f
LOG       ?= sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator, result taken from $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_iommu_fq_top.sv ====
module tb_iommu_fq_top;
    import iommu_fq_pkg::*;

    localparam logic [PLEN-1:0] BASE    = 56'h8_0000;  // Queue base for PPN 0x80
    localparam int              TIMEOUT = 200;         // Cycles allowed for any single wait

    typedef struct packed {
        fq_event_t        ev;
        logic [DID_W-1:0] did;      // Expected record fields from here down
        logic [PID_W-1:0] pid;
        logic             pv;
        logic             priv;
        logic [63:0]      iotval;
        logic [63:0]      iotval2;
    } entry_t;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        reg_we_i;
    logic [1:0]  reg_addr_i;
    logic [63:0] reg_wdata_i;
    logic [63:0] reg_rdata_o;
    logic        event_valid_i;
    fq_event_t   event_i;
    fq_mem_req_t mem_req_o;
    fq_mem_rsp_t mem_rsp_i = '0;
    logic        fq_ip_o;

    logic [63:0]     mem [logic [PLEN-1:0]];  // Sparse model of the record memory
    logic [PLEN-1:0] err_addr;                // Beat address that answers with err
    integer          seed = 32'h4c497696;
    int              gnt_wait = 0;
    entry_t          tab [5];
    logic [63:0]     val;

    iommu_fq_top u_iommu_fq_top (
        .clk_i, .rst_ni, .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
        .event_valid_i, .event_i, .mem_req_o, .mem_rsp_i, .fq_ip_o
    );

    always #20 clk_i = ~clk_i;

    // Memory grants each beat after 0 to 3 idle cycles and stores it unless it faults
    always @(posedge clk_i) begin
        #2;
        mem_rsp_i = '0;
        if (mem_req_o.req) begin
            if (gnt_wait == 0) begin
                mem_rsp_i.gnt = 1'b1;
                mem_rsp_i.err = (mem_req_o.addr == err_addr);
                if (!mem_rsp_i.err) begin
                    mem[mem_req_o.addr] = mem_req_o.wdata;
                end
                gnt_wait = $random(seed) & 3;  // Delay for the next beat
            end else begin
                gnt_wait = gnt_wait - 1;
            end
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reg_write(input logic [1:0] addr, input logic [63:0] data);
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(posedge clk_i);
        #2;
        reg_we_i = 1'b0;
    endtask

    task automatic reg_read(input logic [1:0] addr, output logic [63:0] data);
        reg_addr_i = addr;
        #1;
        data = reg_rdata_o;  // Read path is combinational
    endtask

    // Polls a register each cycle until its masked value matches
    task automatic wait_reg(input logic [1:0] addr, input logic [63:0] mask,
                            input logic [63:0] exp, input string what);
        logic [63:0] rd;
        int          n = 0;
        reg_read(addr, rd);
        while ((rd & mask) !== exp) begin
            if (n == TIMEOUT) begin
                $display("Timeout while waiting for %s", what);
                $display("SOME TESTS FAILED");
                $fatal(1, "wait timed out");
            end else begin
                n++;
                @(posedge clk_i);
                #2;
                reg_read(addr, rd);
            end
        end
    endtask

    task automatic fire_event(input fq_event_t ev);
        event_i       = ev;  // Held afterwards so the builder output stays put
        event_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        event_valid_i = 1'b0;
    endtask

    // Compares the four beats of one slot with the expected record
    task automatic check_slot(input int slot, input entry_t e);
        logic [PLEN-1:0] a;
        a = BASE + PLEN'(slot * 32);
        check("beat 0", mem[a], {e.did, e.ev.ttyp, e.priv, e.pv, e.pid, e.ev.cause});
        check("beat 1", mem[a + 56'd8], 64'h0);
        check("beat 2 iotval", mem[a + 56'd16], e.iotval);
        check("beat 3 iotval2", mem[a + 56'd24], e.iotval2);
    endtask

    initial begin
        rst_ni        = 1'b0;
        reg_we_i      = 1'b0;
        reg_addr_i    = REG_FQCSR;
        reg_wdata_i   = '0;
        event_valid_i = 1'b0;
        event_i       = '0;
        err_addr      = '1;  // No faulting address until the memory error case
        // Untranslated read with a valid PID
        tab[0] = '{'{TTYP_UNTRANSL_READ, 12'd5, 64'h1234_5678_9000, 62'h0, 24'hab_cdef,
                     1'b1, 20'h1_2345, 1'b1, 1'b0, 1'b0},
                   24'hab_cdef, 20'h1_2345, 1'b1, 1'b1, 64'h1234_5678_9000, 64'h0};
        // Write with pv clear drops pid and priv
        tab[1] = '{'{TTYP_UNTRANSL_WRITE, 12'd7, 64'hdead_b000, 62'h0, 24'h00_0042,
                     1'b0, 20'h5_5555, 1'b1, 1'b0, 1'b0},
                   24'h00_0042, 20'h0, 1'b0, 1'b0, 64'hdead_b000, 64'h0};
        tab[2] = '{'{TTYP_NONE, 12'd260, 64'hffff_0000_1111_2000, 62'h0, 24'h12_3456,
                     1'b1, 20'h0_0abc, 1'b1, 1'b0, 1'b0},
                   24'h0, 20'h0, 1'b0, 1'b0, 64'h0, 64'h0};  // Only the cause survives
        // PCIe message keeps its identity and reports no address
        tab[3] = '{'{TTYP_PCIE_MSG, 12'd256, 64'hfeed_0000, 62'h0, 24'h00_0777,
                     1'b1, 20'h0_0011, 1'b0, 1'b0, 1'b0},
                   24'h00_0777, 20'h0_0011, 1'b1, 1'b0, 64'h0, 64'h0};
        // Guest page fault from an implicit access, GPA 0x300_1234 lands shifted by 2
        tab[4] = '{'{TTYP_UNTRANSL_READ, 12'd21, 64'h4000_0000, 62'h300_1234, 24'h00_0100,
                     1'b0, 20'h0_0bad, 1'b0, 1'b1, 1'b1},
                   24'h00_0100, 20'h0, 1'b0, 1'b0, 64'h4000_0000, 64'h0c00_48d1};
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // Eight entries at PPN 0x80, then enable with interrupts
        reg_write(REG_FQB, (64'h80 << FQB_PPN_LSB) | 64'd2);
        reg_write(REG_FQH, 64'd0);
        reg_write(REG_FQCSR, 64'h3);
        reg_read(REG_FQCSR, val);
        check("fqcsr while busy", val, 64'h2_0003);
        @(posedge clk_i);
        #2;
        reg_read(REG_FQCSR, val);
        check("fqcsr once on", val, 64'h1_0003);

        for (int i = 0; i < 5; i++) begin
            fire_event(tab[i].ev);
            wait_reg(REG_FQT, '1, 64'(i + 1), "tail to advance");
            check("fq_ip_o after record", 64'(fq_ip_o), 64'd1);  // Raised as the tail moves
            check_slot(i, tab[i]);
        end
        for (int i = 5; i < 7; i++) begin  // Head stays at 0 so slot 7 is the spare one
            fire_event(tab[0].ev);
            wait_reg(REG_FQT, '1, 64'(i + 1), "tail to advance");
            check_slot(i, tab[0]);
        end
        fire_event(tab[1].ev);
        wait_reg(REG_FQCSR, 64'(1 << CSR_OF), 64'(1 << CSR_OF), "overflow flag");
        check("fq_ip_o on overflow", 64'(fq_ip_o), 64'd1);
        check("slot 7 written", 64'(mem.exists(BASE + 56'd224)), 64'd0);
        reg_read(REG_FQT, val);
        check("fqt after overflow", val, 64'd7);

        // Software consumes four records and clears the flag
        reg_write(REG_FQH, 64'd4);
        reg_write(REG_FQCSR, 64'h203);
        wait_reg(REG_FQCSR, 64'h3_0303, 64'h1_0003, "overflow flag to clear");
        @(posedge clk_i);
        #2;
        check("fq_ip_o after clear", 64'(fq_ip_o), 64'd0);
        fire_event(tab[3].ev);
        wait_reg(REG_FQT, '1, 64'd0, "tail to wrap");
        check_slot(7, tab[3]);

        err_addr = BASE + 56'd8;  // Second beat of slot 0 faults
        fire_event(tab[0].ev);
        wait_reg(REG_FQCSR, 64'(1 << CSR_MF), 64'(1 << CSR_MF), "memory fault flag");
        reg_read(REG_FQT, val);
        check("fqt after memory fault", val, 64'd0);
        err_addr = '1;
        reg_write(REG_FQCSR, 64'h103);
        wait_reg(REG_FQCSR, 64'h3_0303, 64'h1_0003, "memory fault flag to clear");
        @(posedge clk_i);
        #2;
        fire_event(tab[2].ev);
        wait_reg(REG_FQT, '1, 64'd1, "tail to advance");
        check_slot(0, tab[2]);

        // A fault on slot 1 stays pending while the queue is turned off
        err_addr = BASE + 56'd32;  // First beat of slot 1 faults
        fire_event(tab[0].ev);
        wait_reg(REG_FQCSR, 64'(1 << CSR_MF), 64'(1 << CSR_MF), "memory fault flag");
        err_addr = '1;

        // Turning the queue off and on again restarts the tail at 0 with no flags set
        reg_write(REG_FQCSR, 64'h0);
        wait_reg(REG_FQCSR, 64'h3_0003, 64'h0, "queue to turn off");
        reg_write(REG_FQCSR, 64'h3);
        wait_reg(REG_FQCSR, 64'h3_0303, 64'h1_0003, "queue to turn on with flags clear");
        reg_read(REG_FQT, val);
        check("fqt after enable", val, 64'd0);

        $display("ALL TESTS PASSED");
        $finish;
    end
endmodule

// ==== sim/fq_asserts.sv ====
module fq_asserts (
    input logic                      clk_i,
    input logic                      rst_ni,
    input logic                      en_i,        // Enable bit as stored in fqcsr
    input logic                      on_i,
    input logic                      wr_start_i,
    input logic                      wr_done_i,
    input logic                      clear_i,
    input logic [31:0]               tail_i,
    input iommu_fq_pkg::fq_mem_req_t mem_req_i,
    input iommu_fq_pkg::fq_mem_rsp_t mem_rsp_i
);
    // A record starts only from a settled, enabled queue with the writer idle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_start_i |-> (en_i && on_i && !mem_req_i.req))
        else $error("record write started outside an idle enabled queue");

    // The tail moves after a completed record, or is cleared by a fresh enable
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$stable(tail_i) |-> $past(wr_done_i || clear_i))
        else $error("tail changed without a completed record");

    // A pending beat holds address and data until memory grants it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_i.req && !mem_rsp_i.gnt) |=>
            (mem_req_i.req && $stable(mem_req_i.addr) && $stable(mem_req_i.wdata)))
        else $error("memory request changed before its grant");
endmodule

bind iommu_fq_top fq_asserts u_fq_asserts (
    .clk_i, .rst_ni, .en_i(ctrl.en), .on_i(on), .wr_start_i(wr_start), .wr_done_i(wr_done),
    .clear_i(clear), .tail_i(tail), .mem_req_i(mem_req_o), .mem_rsp_i(mem_rsp_i)
);

// ==== src/iommu_fq_top.sv ====
module iommu_fq_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // Software register port
    input  logic                      reg_we_i,
    input  logic [1:0]                reg_addr_i,
    input  logic [63:0]               reg_wdata_i,
    output logic [63:0]               reg_rdata_o,

    // Fault events from translation
    input  logic                      event_valid_i,
    input  iommu_fq_pkg::fq_event_t   event_i,

    // Memory port
    output iommu_fq_pkg::fq_mem_req_t mem_req_o,
    input  iommu_fq_pkg::fq_mem_rsp_t mem_rsp_i,

    output logic                      fq_ip_o  // Fault-pending interrupt
);
    import iommu_fq_pkg::*;

    fq_ctrl_t        ctrl;
    fq_record_u      record;      // Builder output for the event on the bus
    fq_record_u      wr_record;
    logic [31:0]     tail;
    logic            on;
    logic            busy;
    logic            set_mf;
    logic            set_of;
    logic            clear;
    logic            wr_start;
    logic [PLEN-1:0] wr_addr;
    logic            wr_done;
    logic            wr_err;

    fq_regs u_fq_regs (
        .clk_i, .rst_ni, .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
        .tail_i(tail), .on_i(on), .busy_i(busy), .set_mf_i(set_mf),
        .set_of_i(set_of), .clear_i(clear), .ctrl_o(ctrl)
    );

    fq_record_builder u_fq_record_builder (.event_i, .record_o(record));

    fq_handler u_fq_handler (
        .clk_i, .rst_ni, .ctrl_i(ctrl), .event_valid_i, .record_i(record),
        .tail_o(tail), .on_o(on), .busy_o(busy), .set_mf_o(set_mf), .set_of_o(set_of),
        .clear_o(clear), .ip_o(fq_ip_o), .wr_start_o(wr_start), .wr_addr_o(wr_addr),
        .wr_record_o(wr_record), .wr_done_i(wr_done), .wr_err_i(wr_err)
    );

    fq_mem_writer u_fq_mem_writer (
        .clk_i, .rst_ni, .start_i(wr_start), .addr_i(wr_addr), .record_i(wr_record),
        .mem_req_o, .mem_rsp_i, .done_o(wr_done), .err_o(wr_err)
    );

endmodule

// ==== src/fq_mem_writer.sv ====
module fq_mem_writer (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    input  logic                          start_i,   // Latch a record and begin the beats
    input  logic [iommu_fq_pkg::PLEN-1:0] addr_i,    // Slot address of beat 0
    input  iommu_fq_pkg::fq_record_u      record_i,

    output iommu_fq_pkg::fq_mem_req_t     mem_req_o,
    input  iommu_fq_pkg::fq_mem_rsp_t     mem_rsp_i,

    output logic                          done_o,    // Last beat granted without error
    output logic                          err_o      // A granted beat reported an error
);
    import iommu_fq_pkg::*;

    logic             busy_q;
    logic [1:0]       beat_q;
    fq_record_u       record_q;
    logic [PLEN-1:0]  addr_q;
    logic             beat_ok;  // Current beat accepted by memory
    logic             last_beat;

    assign last_beat = (beat_q == 2'(NUM_BEATS - 1));
    assign beat_ok   = busy_q && mem_rsp_i.gnt;

    // Request holds steady until granted since beat_q only moves on gnt
    assign mem_req_o.req   = busy_q;
    assign mem_req_o.addr  = addr_q + PLEN'({beat_q, 3'b000});  // 8 bytes per beat
    assign mem_req_o.wdata = record_q.beat[beat_q];

    assign err_o  = beat_ok && mem_rsp_i.err;
    assign done_o = beat_ok && !mem_rsp_i.err && last_beat;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            beat_q <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            beat_q <= '0;
        end else if (err_o || done_o) begin
            busy_q <= 1'b0;  // Stop at the first error and send nothing more
            beat_q <= '0;
        end else if (beat_ok) begin
            beat_q <= beat_q + 2'd1;
        end
    end

    // Payload is captured once per record
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            record_q <= record_i;
            addr_q   <= addr_i;
        end
    end

endmodule

// ==== src/fq_handler.sv ====
module fq_handler (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    input  iommu_fq_pkg::fq_ctrl_t        ctrl_i,

    // Event path
    input  logic                          event_valid_i,
    input  iommu_fq_pkg::fq_record_u      record_i,      // Formatted record of the current event

    // Status back to the registers
    output logic [31:0]                   tail_o,
    output logic                          on_o,
    output logic                          busy_o,
    output logic                          set_mf_o,
    output logic                          set_of_o,
    output logic                          clear_o,       // Pulses on the rising edge of enable
    output logic                          ip_o,

    // Memory writer control
    output logic                          wr_start_o,
    output logic [iommu_fq_pkg::PLEN-1:0] wr_addr_o,
    output iommu_fq_pkg::fq_record_u      wr_record_o,
    input  logic                          wr_done_i,
    input  logic                          wr_err_i
);
    import iommu_fq_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        ERROR
    } state_e;

    state_e      state_q, state_d;
    logic        en_q;        // Enable as last followed by the handler
    logic [31:0] tail_q, tail_d;
    logic        ip_q, ip_d;

    logic [4:0]  size_eff;
    logic [31:0] idx_mask;    // Index bits that fit in the queue
    logic        full;
    logic        accept;

    // Queues beyond 4096 entries are treated as 4096
    assign size_eff = (ctrl_i.size > 5'(QSIZE_MAX)) ? 5'(QSIZE_MAX) : ctrl_i.size;
    assign idx_mask = ~({32{1'b1}} << (size_eff + 5'd1));

    // One slot stays empty so that head equal to tail means empty
    assign full = (tail_q == ((ctrl_i.head - 32'd1) & idx_mask));

    // Events are only taken once the enable has settled
    assign accept = (state_q == IDLE) && event_valid_i && ctrl_i.en && en_q;

    assign busy_o  = (ctrl_i.en != en_q);
    assign on_o    = en_q;
    assign clear_o = ctrl_i.en && !en_q;
    assign tail_o  = tail_q;

    // Slot is base plus 32 bytes per entry
    assign wr_addr_o   = PLEN'({ctrl_i.base_ppn, 12'h000}) | PLEN'({tail_q & idx_mask, 5'b0});
    assign wr_record_o = record_i;  // Writer captures it on wr_start

    // Pending level holds for the whole error stop
    assign ip_o = ip_q || ((state_q == ERROR) && ctrl_i.ie);

    always_comb begin
        state_d    = state_q;
        tail_d     = tail_q;
        ip_d       = 1'b0;
        set_mf_o   = 1'b0;
        set_of_o   = 1'b0;
        wr_start_o = 1'b0;

        case (state_q)
            IDLE: begin
                if (clear_o) begin
                    tail_d = '0;  // Fresh queue starts at slot 0
                end else if (accept) begin
                    if (full) begin
                        set_of_o = 1'b1;  // Drop the event and stop recording
                        state_d  = ERROR;
                    end else begin
                        wr_start_o = 1'b1;
                        state_d    = WRITE;
                    end
                end
            end
            WRITE: begin
                if (wr_err_i) begin
                    set_mf_o = 1'b1;  // Tail stays on the failed slot
                    state_d  = ERROR;
                end else if (wr_done_i) begin
                    tail_d  = (tail_q + 32'd1) & idx_mask;
                    ip_d    = ctrl_i.ie;
                    state_d = IDLE;
                end
            end
            ERROR: begin
                if (clear_o) begin
                    tail_d = '0;
                end
                // Wait for software to clear both flags
                if (!ctrl_i.mf && !ctrl_i.of) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            en_q    <= 1'b0;
            tail_q  <= '0;
            ip_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            tail_q  <= tail_d;
            ip_q    <= ip_d;
            if (state_q != WRITE) begin
                en_q <= ctrl_i.en;  // No enable change while a record is in flight
            end
        end
    end

endmodule

// ==== src/fq_record_builder.sv ====
module fq_record_builder (
    input  iommu_fq_pkg::fq_event_t  event_i,
    output iommu_fq_pkg::fq_record_u record_o
);
    import iommu_fq_pkg::*;

    logic has_ttyp;   // Event belongs to a real transaction
    logic has_iova;   // Transaction carries an address worth reporting
    logic pid_valid;

    assign has_ttyp  = (event_i.ttyp != TTYP_NONE);
    assign has_iova  = has_ttyp && (event_i.ttyp != TTYP_PCIE_MSG);  // Messages have no address
    assign pid_valid = has_ttyp && event_i.pv;

    always_comb begin
        record_o = '0;  // Reserved bytes and unreported fields stay zero

        // Cause and type are always reported
        record_o.fields.cause = event_i.cause;
        record_o.fields.ttyp  = event_i.ttyp;

        // Device and process identity only exist for a real transaction
        if (has_ttyp) begin
            record_o.fields.did = event_i.did;
            record_o.fields.pv  = event_i.pv;
        end

        // PID and privilege are only meaningful with a valid process ID
        if (pid_valid) begin
            record_o.fields.pid  = event_i.pid;
            record_o.fields.priv = event_i.priv;
        end

        if (has_iova) begin
            record_o.fields.iotval = event_i.iova;
        end

        // A guest page fault reports GPA bits 63:2 in place
        // Bit 1 stays 0 as A/D updates are not implemented
        if (event_i.guest_pf) begin
            record_o.fields.iotval2 = {event_i.gpa, 1'b0, event_i.implicit};
        end
    end

endmodule

// ==== src/fq_regs.sv ====
module fq_regs (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    // Software register port
    input  logic                   reg_we_i,
    input  logic [1:0]             reg_addr_i,
    input  logic [63:0]            reg_wdata_i,
    output logic [63:0]            reg_rdata_o,

    // Status from the handler
    input  logic [31:0]            tail_i,
    input  logic                   on_i,
    input  logic                   busy_i,
    input  logic                   set_mf_i,  // Memory fault seen on a record write
    input  logic                   set_of_i,  // Event arrived with the queue full
    input  logic                   clear_i,   // Queue was just enabled

    output iommu_fq_pkg::fq_ctrl_t ctrl_o
);
    import iommu_fq_pkg::*;

    logic [PPN_W-1:0] base_ppn_q;
    logic [4:0]       size_q;
    logic [31:0]      head_q;
    logic             en_q;
    logic             ie_q;
    logic             mf_q;
    logic             of_q;

    logic             wr_fqb;
    logic             wr_fqh;
    logic             wr_csr;

    // fqb may only move while the queue is fully off
    assign wr_fqb = reg_we_i && (reg_addr_i == REG_FQB) && !on_i && !busy_i;
    assign wr_fqh = reg_we_i && (reg_addr_i == REG_FQH);
    assign wr_csr = reg_we_i && (reg_addr_i == REG_FQCSR);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            base_ppn_q <= '0;
            size_q     <= '0;
            head_q     <= '0;
            en_q       <= 1'b0;
            ie_q       <= 1'b0;
        end else begin
            if (wr_fqb) begin
                base_ppn_q <= reg_wdata_i[FQB_PPN_LSB +: PPN_W];
                size_q     <= reg_wdata_i[4:0];
            end
            if (wr_fqh) begin
                head_q <= reg_wdata_i[31:0];  // Software has consumed records up to here
            end
            if (wr_csr && !busy_i) begin  // Control bits hold while a transition is pending
                en_q <= reg_wdata_i[CSR_EN];
                ie_q <= reg_wdata_i[CSR_IE];
            end
        end
    end

    // Error flags are set by the handler and cleared by writing 1
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mf_q <= 1'b0;
            of_q <= 1'b0;
        end else if (clear_i) begin
            mf_q <= 1'b0;  // A fresh enable starts with no errors
            of_q <= 1'b0;
        end else begin
            if (set_mf_i) begin
                mf_q <= 1'b1;  // A new fault wins over a clear in the same cycle
            end else if (wr_csr && reg_wdata_i[CSR_MF]) begin
                mf_q <= 1'b0;
            end
            if (set_of_i) begin
                of_q <= 1'b1;
            end else if (wr_csr && reg_wdata_i[CSR_OF]) begin
                of_q <= 1'b0;
            end
        end
    end

    always_comb begin
        reg_rdata_o = '0;
        case (reg_addr_i)
            REG_FQB: begin
                reg_rdata_o[FQB_PPN_LSB +: PPN_W] = base_ppn_q;
                reg_rdata_o[4:0]                  = size_q;
            end
            REG_FQH:   reg_rdata_o[31:0] = head_q;
            REG_FQT:   reg_rdata_o[31:0] = tail_i;  // Tail is owned by the handler
            default: begin
                reg_rdata_o[CSR_EN]   = en_q;
                reg_rdata_o[CSR_IE]   = ie_q;
                reg_rdata_o[CSR_MF]   = mf_q;
                reg_rdata_o[CSR_OF]   = of_q;
                reg_rdata_o[CSR_ON]   = on_i;
                reg_rdata_o[CSR_BUSY] = busy_i;
            end
        endcase
    end

    assign ctrl_o = '{base_ppn: base_ppn_q, size: size_q, head: head_q,
                      en: en_q, ie: ie_q, mf: mf_q, of: of_q};

endmodule

// ==== src/iommu_fq_pkg.sv ====
package iommu_fq_pkg;

    // Address and identifier widths
    localparam int PPN_W     = 44;  // Base physical page number of the queue
    localparam int PLEN      = 56;  // Physical address width
    localparam int DID_W     = 24;  // Device ID
    localparam int PID_W     = 20;  // Process ID
    localparam int CAUSE_W   = 12;  // Fault cause code
    localparam int TTYP_W    = 6;   // Transaction type
    localparam int GPA_W     = 62;  // Bits 63:2 of the guest physical address
    localparam int QSIZE_MAX = 11;  // Largest log2 size minus one, so at most 4096 entries

    localparam int BEAT_W    = 64;  // One memory write beat
    localparam int NUM_BEATS = 4;   // Beats per 32-byte record

    // Transaction types that change how a record is filled
    localparam logic [TTYP_W-1:0] TTYP_NONE           = 6'd0;
    localparam logic [TTYP_W-1:0] TTYP_UNTRANSL_READ  = 6'd1;
    localparam logic [TTYP_W-1:0] TTYP_UNTRANSL_WRITE = 6'd3;
    localparam logic [TTYP_W-1:0] TTYP_PCIE_MSG       = 6'd9;

    // Register port addresses
    localparam logic [1:0] REG_FQB   = 2'd0;
    localparam logic [1:0] REG_FQH   = 2'd1;
    localparam logic [1:0] REG_FQT   = 2'd2;
    localparam logic [1:0] REG_FQCSR = 2'd3;

    // Bit positions inside fqb and fqcsr
    localparam int FQB_PPN_LSB = 10;  // PPN sits at fqb[53:10], log2 size minus one at fqb[4:0]
    localparam int CSR_EN      = 0;
    localparam int CSR_IE      = 1;
    localparam int CSR_MF      = 8;
    localparam int CSR_OF      = 9;
    localparam int CSR_ON      = 16;
    localparam int CSR_BUSY    = 17;

    // Record fields, listed from the most significant bit down
    typedef struct packed {
        logic [BEAT_W-1:0]  iotval2;   // Bytes 31:24
        logic [BEAT_W-1:0]  iotval;    // Bytes 23:16
        logic [BEAT_W-1:0]  reserved;  // Bytes 15:8
        logic [DID_W-1:0]   did;
        logic [TTYP_W-1:0]  ttyp;
        logic               priv;
        logic               pv;
        logic [PID_W-1:0]   pid;
        logic [CAUSE_W-1:0] cause;     // Lowest bits of beat 0
    } fq_record_fields_t;

    // The builder fills named fields and the writer walks the same word beat by beat
    typedef union packed {
        fq_record_fields_t                   fields;
        logic [NUM_BEATS-1:0][BEAT_W-1:0]    beat;    // Beat 0 goes to the lowest address
    } fq_record_u;

    // Fault event as raised by the translation logic
    typedef struct packed {
        logic [TTYP_W-1:0]  ttyp;
        logic [CAUSE_W-1:0] cause;
        logic [63:0]        iova;
        logic [GPA_W-1:0]   gpa;
        logic [DID_W-1:0]   did;
        logic               pv;
        logic [PID_W-1:0]   pid;
        logic               priv;      // Supervisor privilege of the transaction
        logic               guest_pf;  // Event is a guest page fault
        logic               implicit;  // Guest fault came from an implicit first-stage access
    } fq_event_t;

    typedef struct packed {
        logic              req;
        logic [PLEN-1:0]   addr;
        logic [BEAT_W-1:0] wdata;
    } fq_mem_req_t;

    typedef struct packed {
        logic gnt;
        logic err;  // Only meaningful together with gnt
    } fq_mem_rsp_t;

    // Register state seen by the queue handler
    typedef struct packed {
        logic [PPN_W-1:0] base_ppn;
        logic [4:0]       size;      // Log2 of the entry count minus one
        logic [31:0]      head;
        logic             en;
        logic             ie;
        logic             mf;
        logic             of;
    } fq_ctrl_t;

endpackage
